//--- source/fpu_num_pkg.sv
// number format types for the alignment stage
// exponents, extended exponent, mantissa byte, shift count
`default_nettype none

package fpu_num_pkg;

	// signed exponent as it arrives on the inputs
	typedef logic signed [7:0] exponent_t;

	// two extra bits above the sign
	// adder result and D register
	typedef logic signed [9:0] exp_ext_t;

	// one slice of the mantissa
	typedef logic [7:0] mant_byte_t;

	// alignment shift count, enough for the full mantissa width
	typedef logic [5:0] shift_cnt_t;

endpackage

`default_nettype wire

//--- source/fpu_op_pkg.sv
// operation codes and sequencer states
`default_nettype none

package fpu_op_pkg;

	typedef logic [2:0] op_code_t;

	// fixed point group
	localparam op_code_t OP_AD = 3'd0;
	localparam op_code_t OP_SD = 3'd1;
	localparam op_code_t OP_MW = 3'd2;
	localparam op_code_t OP_DW = 3'd3;

	// floating point group, bit 2 set
	localparam op_code_t OP_AF = 3'd4;
	localparam op_code_t OP_SF = 3'd5;
	localparam op_code_t OP_MF = 3'd6;
	localparam op_code_t OP_DF = 3'd7;

	typedef enum logic [1:0] {
		IDLE,
		DIFF,
		SHIFT,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

//--- source/op_decoder.sv
// operation code register and decoder
// one-hot float operation levels, float/fixed class levels
`timescale 1ns/1ps
`default_nettype none

module op_decoder (
	input wire clk_sys,
	input wire _0_f,
	input wire accept,
	input wire fpu_op_pkg::op_code_t ir,
	output logic af_sf,
	output logic mf,
	output logic df,
	output logic ff,
	output logic ss
);

	fpu_op_pkg::op_code_t ir_q;
	// set by the first accepted operation, keeps class levels quiet after reset
	logic op_valid;

	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			ir_q <= '0;
			op_valid <= 1'b0;
		end else if (accept) begin
			ir_q <= ir;
			op_valid <= 1'b1;
		end
	end

	assign af_sf = (ir_q == fpu_op_pkg::OP_AF) | (ir_q == fpu_op_pkg::OP_SF);
	assign mf = ir_q == fpu_op_pkg::OP_MF;
	assign df = ir_q == fpu_op_pkg::OP_DF;

	// class levels
	assign ff = op_valid & (ir_q inside {fpu_op_pkg::OP_AF, fpu_op_pkg::OP_SF,
		fpu_op_pkg::OP_MF, fpu_op_pkg::OP_DF});
	assign ss = op_valid & (ir_q inside {fpu_op_pkg::OP_AD, fpu_op_pkg::OP_SD,
		fpu_op_pkg::OP_MW, fpu_op_pkg::OP_DW});

endmodule

`default_nettype wire

//--- source/exp_path.sv
// exponent path
// D and B registers, L bus select, exponent adder,
// alignment range and overflow/underflow detectors
`timescale 1ns/1ps
`default_nettype none

module exp_path #(
	parameter int ALIGN_LIMIT = 40
) (
	input wire clk_sys,
	input wire _0_f,
	input wire accept,
	input wire fpu_num_pkg::exponent_t exp_a,
	input wire fpu_num_pkg::exponent_t exp_b,
	input wire sub_mode,
	input wire d_from_sum,
	input wire d_from_b,
	output fpu_num_pkg::exp_ext_t sum,
	output logic big_diff,
	output logic sum_neg,
	output logic ovf,
	output logic unf,
	output fpu_num_pkg::exponent_t exp_out
);

	fpu_num_pkg::exp_ext_t d_q;
	fpu_num_pkg::exponent_t b_q;
	fpu_num_pkg::exp_ext_t l_bus;
	fpu_num_pkg::exp_ext_t b_ext;
	fpu_num_pkg::exp_ext_t b_bus;
	logic l_d;

	assign b_ext = {{2{b_q[7]}}, b_q};

	// L bus source
	always_comb begin
		if (accept) begin
			l_bus = {{2{exp_a[7]}}, exp_a};
		end else if (d_from_sum) begin
			l_bus = sum;
		end else begin
			l_bus = b_ext;
		end
	end

	assign l_d = accept | d_from_sum | d_from_b;

	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			d_q <= '0;
		end else if (l_d) begin
			d_q <= l_bus;
		end
	end

	// B only changes when a new operation is taken
	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			b_q <= '0;
		end else if (accept) begin
			b_q <= exp_b;
		end
	end

	// two's complement of B for D-B
	assign b_bus = sub_mode ? (~b_ext + 10'sd1) : b_ext;

	assign sum = d_q + b_bus;
	assign sum_neg = sum[9];

	// |sum| >= alignment limit
	assign big_diff = (sum >= ALIGN_LIMIT) || (sum <= -ALIGN_LIMIT);

	// extension bits disagree with bit 7
	// positive side is overflow, negative side is underflow
	assign ovf = ~d_q[9] & (d_q[8] | d_q[7]);
	assign unf = d_q[9] & ~(d_q[8] & d_q[7]);

	assign exp_out = d_q[7:0];

endmodule

`default_nettype wire

//--- source/align_seq.sv
// alignment sequencer
// IDLE/DIFF/SHIFT/DONE state machine, shift down-counter,
// g, wdt and exponent fault indicators, all strobes and done pulse
`timescale 1ns/1ps
`default_nettype none

module align_seq #(
	parameter int MANT_BYTES = 5
) (
	input wire clk_sys,
	input wire _0_f,
	input wire start,
	input wire af_sf,
	input wire mf,
	input wire df,
	input wire ff,
	input wire fpu_num_pkg::exp_ext_t sum,
	input wire big_diff,
	input wire sum_neg,
	input wire ovf,
	input wire unf,
	output logic accept,
	output logic sub_mode,
	output logic d_from_sum,
	output logic d_from_b,
	output logic shift,
	output logic clear,
	output logic sample,
	output logic busy,
	output logic done,
	output logic g,
	output logic wdt,
	output logic fi_ovf,
	output logic fi_unf
);

	// counter bits actually taken from the difference
	localparam int CNT_W = $clog2(8 * MANT_BYTES);

	fpu_op_pkg::seq_state_t state;
	fpu_op_pkg::seq_state_t state_nx;
	fpu_num_pkg::shift_cnt_t cnt;
	fpu_num_pkg::exp_ext_t sum_mag;
	logic float_align;
	logic float_exp;
	logic in_diff;
	logic in_shift;
	logic in_done;
	logic shift_run;

	assign float_align = ff & af_sf;
	assign float_exp = ff & (mf | df);

	assign in_diff = state == fpu_op_pkg::DIFF;
	assign in_shift = state == fpu_op_pkg::SHIFT;
	assign in_done = state == fpu_op_pkg::DONE;

	assign accept = (state == fpu_op_pkg::IDLE) & start;
	assign busy = state != fpu_op_pkg::IDLE;

	assign sum_mag = sum_neg ? -sum : sum;
	// A smaller and within range
	assign shift_run = float_align & sum_neg & ~big_diff;

	// strobes
	assign sub_mode = in_diff & (float_align | (float_exp & df));
	assign d_from_sum = in_diff & float_exp;
	assign clear = in_diff & float_align & sum_neg & big_diff;
	assign shift = in_shift;
	assign d_from_b = in_done & float_align & wdt;
	assign sample = in_done;

	always_comb begin
		state_nx = state;
		case (state)
			fpu_op_pkg::IDLE:
				if (start) state_nx = fpu_op_pkg::DIFF;
			fpu_op_pkg::DIFF:
				state_nx = shift_run ? fpu_op_pkg::SHIFT : fpu_op_pkg::DONE;
			fpu_op_pkg::SHIFT:
				if (cnt == fpu_num_pkg::shift_cnt_t'(1)) state_nx = fpu_op_pkg::DONE;
			fpu_op_pkg::DONE:
				state_nx = fpu_op_pkg::IDLE;
			default:
				state_nx = fpu_op_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			state <= fpu_op_pkg::IDLE;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			state <= state_nx;
			done <= in_done;
			if (in_diff & shift_run) begin
				cnt <= fpu_num_pkg::shift_cnt_t'(sum_mag[CNT_W-1:0]);
			end else if (in_shift) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// difference indicators, only af/sf may set them
	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			g <= 1'b0;
			wdt <= 1'b0;
		end else if (in_diff) begin
			g <= float_align & big_diff;
			wdt <= float_align & sum_neg;
		end
	end

	// exponent faults, D already holds the mf/df result here
	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			fi_ovf <= 1'b0;
			fi_unf <= 1'b0;
		end else if (in_done) begin
			fi_ovf <= float_exp & ovf;
			fi_unf <= float_exp & unf;
		end
	end

endmodule

`default_nettype wire

//--- source/mant_byte_slice.sv
// one mantissa byte
// clear, load, arithmetic right shift through the chain, zero detect
`timescale 1ns/1ps
`default_nettype none

module mant_byte_slice (
	input wire clk_sys,
	input wire _0_f,
	input wire load,
	input wire fpu_num_pkg::mant_byte_t load_byte,
	input wire shift,
	input wire clear,
	input wire shift_in,
	output fpu_num_pkg::mant_byte_t byte_q,
	output logic shift_out,
	output logic zero
);

	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			byte_q <= '0;
		end else if (clear) begin
			byte_q <= '0;
		end else if (load) begin
			byte_q <= load_byte;
		end else if (shift) begin
			// msb comes from the slice above
			byte_q <= {shift_in, byte_q[7:1]};
		end
	end

	// lsb moves down to the next slice
	assign shift_out = byte_q[0];

	assign zero = byte_q == '0;

endmodule

`default_nettype wire

//--- source/mant_status.sv
// mantissa status indicators
// zero, normalized and unnormalized, sampled at end of operation
`timescale 1ns/1ps
`default_nettype none

module mant_status #(
	parameter int MANT_BYTES = 5
) (
	input wire clk_sys,
	input wire _0_f,
	input wire sample,
	input wire [MANT_BYTES-1:0] slice_zero,
	input wire fpu_num_pkg::mant_byte_t top_byte,
	output logic mant_zero,
	output logic mant_norm,
	output logic mant_unnorm
);

	logic all_zero;
	logic top_differ;

	assign all_zero = &slice_zero;
	// sign and first magnitude bit
	assign top_differ = top_byte[7] ^ top_byte[6];

	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			mant_zero <= 1'b0;
			mant_norm <= 1'b0;
			mant_unnorm <= 1'b0;
		end else if (sample) begin
			mant_zero <= all_zero;
			mant_norm <= ~all_zero & top_differ;
			mant_unnorm <= ~all_zero & ~top_differ;
		end
	end

endmodule

`default_nettype wire

//--- source/fpu_align_top.sv
// exponent and alignment stage top level
// decoder, exponent path, sequencer, mantissa slice array, status
`timescale 1ns/1ps
`default_nettype none

module fpu_align_top #(
	parameter int MANT_BYTES = 5
) (
	input wire clk_sys,
	input wire _0_f,
	input wire start,
	input wire fpu_op_pkg::op_code_t ir,
	input wire fpu_num_pkg::exponent_t exp_a,
	input wire fpu_num_pkg::exponent_t exp_b,
	input wire [8*MANT_BYTES-1:0] mant_in,
	output logic busy,
	output logic done,
	output fpu_num_pkg::exponent_t exp_out,
	output logic [8*MANT_BYTES-1:0] mant_out,
	output logic g,
	output logic wdt,
	output logic fi_ovf,
	output logic fi_unf,
	output logic mant_zero,
	output logic mant_norm,
	output logic mant_unnorm,
	output logic ff,
	output logic ss
);

	logic accept;
	logic af_sf;
	logic mf;
	logic df;
	fpu_num_pkg::exp_ext_t sum;
	logic big_diff;
	logic sum_neg;
	logic ovf;
	logic unf;
	logic sub_mode;
	logic d_from_sum;
	logic d_from_b;
	logic shift;
	logic clear;
	logic sample;
	logic [MANT_BYTES-1:0] slice_zero;
	// bit i+1 feeds slice i, top bit is the sign
	logic [MANT_BYTES:0] shift_chain;

	op_decoder u_op_decoder (
		.clk_sys(clk_sys),
		._0_f(_0_f),
		.accept(accept),
		.ir(ir),
		.af_sf(af_sf),
		.mf(mf),
		.df(df),
		.ff(ff),
		.ss(ss)
	);

	exp_path #(
		.ALIGN_LIMIT(8 * MANT_BYTES)
	) u_exp_path (
		.clk_sys(clk_sys),
		._0_f(_0_f),
		.accept(accept),
		.exp_a(exp_a),
		.exp_b(exp_b),
		.sub_mode(sub_mode),
		.d_from_sum(d_from_sum),
		.d_from_b(d_from_b),
		.sum(sum),
		.big_diff(big_diff),
		.sum_neg(sum_neg),
		.ovf(ovf),
		.unf(unf),
		.exp_out(exp_out)
	);

	align_seq #(
		.MANT_BYTES(MANT_BYTES)
	) u_align_seq (
		.clk_sys(clk_sys),
		._0_f(_0_f),
		.start(start),
		.af_sf(af_sf),
		.mf(mf),
		.df(df),
		.ff(ff),
		.sum(sum),
		.big_diff(big_diff),
		.sum_neg(sum_neg),
		.ovf(ovf),
		.unf(unf),
		.accept(accept),
		.sub_mode(sub_mode),
		.d_from_sum(d_from_sum),
		.d_from_b(d_from_b),
		.shift(shift),
		.clear(clear),
		.sample(sample),
		.busy(busy),
		.done(done),
		.g(g),
		.wdt(wdt),
		.fi_ovf(fi_ovf),
		.fi_unf(fi_unf)
	);

	// sign extension on arithmetic shift
	assign shift_chain[MANT_BYTES] = mant_out[8*MANT_BYTES-1];

	genvar i;
	generate
		for (i = 0; i < MANT_BYTES; i++) begin : g_slice
			mant_byte_slice u_slice (
				.clk_sys(clk_sys),
				._0_f(_0_f),
				.load(accept),
				.load_byte(mant_in[8*i +: 8]),
				.shift(shift),
				.clear(clear),
				.shift_in(shift_chain[i+1]),
				.byte_q(mant_out[8*i +: 8]),
				.shift_out(shift_chain[i]),
				.zero(slice_zero[i])
			);
		end
	endgenerate

	mant_status #(
		.MANT_BYTES(MANT_BYTES)
	) u_mant_status (
		.clk_sys(clk_sys),
		._0_f(_0_f),
		.sample(sample),
		.slice_zero(slice_zero),
		.top_byte(mant_out[8*MANT_BYTES-1 -: 8]),
		.mant_zero(mant_zero),
		.mant_norm(mant_norm),
		.mant_unnorm(mant_unnorm)
	);

endmodule

`default_nettype wire

//--- verif/fpu_align_tb.sv
// directed testbench for the exponent and alignment stage
// clock and reset, compare tasks, operation driver, test tasks
`timescale 1ns/1ps
`default_nettype none

module fpu_align_tb;

	localparam int MANT_BYTES = 5;
	localparam int MANT_W = 8 * MANT_BYTES;
	localparam int LIMIT = 8 * MANT_BYTES;
	localparam int TIMEOUT_CYCLES = 200;

	logic clk_sys;
	logic _0_f;
	logic start;
	fpu_op_pkg::op_code_t ir;
	fpu_num_pkg::exponent_t exp_a;
	fpu_num_pkg::exponent_t exp_b;
	logic [MANT_W-1:0] mant_in;
	logic busy;
	logic done;
	fpu_num_pkg::exponent_t exp_out;
	logic [MANT_W-1:0] mant_out;
	logic g;
	logic wdt;
	logic fi_ovf;
	logic fi_unf;
	logic mant_zero;
	logic mant_norm;
	logic mant_unnorm;
	logic ff;
	logic ss;

	fpu_align_top #(
		.MANT_BYTES(MANT_BYTES)
	) dut0 (
		.clk_sys(clk_sys),
		._0_f(_0_f),
		.start(start),
		.ir(ir),
		.exp_a(exp_a),
		.exp_b(exp_b),
		.mant_in(mant_in),
		.busy(busy),
		.done(done),
		.exp_out(exp_out),
		.mant_out(mant_out),
		.g(g),
		.wdt(wdt),
		.fi_ovf(fi_ovf),
		.fi_unf(fi_unf),
		.mant_zero(mant_zero),
		.mant_norm(mant_norm),
		.mant_unnorm(mant_unnorm),
		.ff(ff),
		.ss(ss)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_exp(input string name, input fpu_num_pkg::exponent_t got,
		input fpu_num_pkg::exponent_t want);
		if (got !== want) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_mant(input string name, input logic [MANT_W-1:0] got,
		input logic [MANT_W-1:0] want);
		if (got !== want) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, want);
			abort_run();
		end
	endtask

	function automatic logic [MANT_W-1:0] rand_mant();
		logic [63:0] r;
		r = {$urandom, $urandom};
		return r[MANT_W-1:0];
	endfunction

	function automatic logic [MANT_W-1:0] shift_right_arith(input logic [MANT_W-1:0] m,
		input int n);
		logic signed [MANT_W-1:0] s;
		s = m;
		return s >>> n;
	endfunction

	// one operation from start to done, n is the expected shift count
	task automatic run_op(input fpu_op_pkg::op_code_t op, input int a_i, input int b_i,
		input logic [MANT_W-1:0] m, input int n, input bit intrude);
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		ir = op;
		exp_a = fpu_num_pkg::exponent_t'(a_i);
		exp_b = fpu_num_pkg::exponent_t'(b_i);
		mant_in = m;
		start = 1'b1;
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			#5;
			cycles++;
			start = 1'b0;
			if (done) begin
				seen = 1'b1;
			end else begin
				check_flag("busy", busy, 1'b1);
				if (intrude && cycles == 6) begin
					// second request in the middle of the shift
					ir = fpu_op_pkg::OP_MF;
					exp_a = fpu_num_pkg::exponent_t'($urandom);
					exp_b = fpu_num_pkg::exponent_t'($urandom);
					mant_in = rand_mant();
					start = 1'b1;
				end
			end
		end
		if (!seen) begin
			$display("timeout: done did not arrive within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
		if (cycles != 3 + n) begin
			$display("done arrived %0d cycles after start instead of %0d", cycles, 3 + n);
			abort_run();
		end
		// single cycle pulse
		@(posedge clk_sys);
		#5;
		check_flag("done", done, 1'b0);
	endtask

	task automatic check_result(input int exp_e, input logic [MANT_W-1:0] mant_e,
		input logic g_e, input logic wdt_e, input logic ovf_e, input logic unf_e);
		logic nz;
		logic top_eq;
		nz = mant_e != '0;
		top_eq = mant_e[MANT_W-1] == mant_e[MANT_W-2];
		check_exp("exp_out", exp_out, fpu_num_pkg::exponent_t'(exp_e));
		check_mant("mant_out", mant_out, mant_e);
		check_flag("g", g, g_e);
		check_flag("wdt", wdt, wdt_e);
		check_flag("fi_ovf", fi_ovf, ovf_e);
		check_flag("fi_unf", fi_unf, unf_e);
		check_flag("mant_zero", mant_zero, !nz);
		check_flag("mant_norm", mant_norm, nz && !top_eq);
		check_flag("mant_unnorm", mant_unnorm, nz && top_eq);
	endtask

	// af/sf, the larger exponent wins and A is aligned to it
	task automatic align_case(input fpu_op_pkg::op_code_t op, input int a_i, input int b_i,
		input logic [MANT_W-1:0] m, input bit intrude);
		int diff;
		bit a_small;
		bit far;
		int n;
		logic [MANT_W-1:0] m_e;
		diff = a_i - b_i;
		a_small = diff < 0;
		far = (diff >= LIMIT) || (diff <= -LIMIT);
		n = (a_small && !far) ? -diff : 0;
		m_e = (a_small && far) ? '0 : shift_right_arith(m, n);
		run_op(op, a_i, b_i, m, n, intrude);
		check_result(a_small ? b_i : a_i, m_e, far, a_small, 1'b0, 1'b0);
	endtask

	// mf adds, df subtracts, faults from the true result range
	task automatic exp_case(input fpu_op_pkg::op_code_t op, input int a_i, input int b_i);
		int r;
		logic [MANT_W-1:0] m;
		r = (op == fpu_op_pkg::OP_MF) ? a_i + b_i : a_i - b_i;
		m = rand_mant();
		run_op(op, a_i, b_i, m, 0, 1'b0);
		check_result(r, m, 1'b0, 1'b0, r > 127, r < -128);
	endtask

	// status flags stay low until the first sample
	task automatic test_reset();
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_exp("exp_out", exp_out, '0);
		check_mant("mant_out", mant_out, '0);
		check_flag("g", g, 1'b0);
		check_flag("wdt", wdt, 1'b0);
		check_flag("fi_ovf", fi_ovf, 1'b0);
		check_flag("fi_unf", fi_unf, 1'b0);
		check_flag("mant_zero", mant_zero, 1'b0);
		check_flag("mant_norm", mant_norm, 1'b0);
		check_flag("mant_unnorm", mant_unnorm, 1'b0);
		check_flag("ff", ff, 1'b0);
		check_flag("ss", ss, 1'b0);
	endtask

	task automatic test_align();
		int d;
		int b_i;
		int a_i;
		for (int k = 0; k < 20; k++) begin
			d = 1 + int'($urandom % 39);
			b_i = -128 + d + int'($urandom % (256 - d));
			align_case(k[0] ? fpu_op_pkg::OP_SF : fpu_op_pkg::OP_AF, b_i - d, b_i,
				rand_mant(), 1'b0);
		end
		check_flag("ff", ff, 1'b1);
		check_flag("ss", ss, 1'b0);
		// A larger or equal
		for (int k = 0; k < 20; k++) begin
			d = int'($urandom % 40);
			a_i = -128 + d + int'($urandom % (256 - d));
			align_case(fpu_op_pkg::OP_AF, a_i, a_i - d, rand_mant(), 1'b0);
		end
		align_case(fpu_op_pkg::OP_SF, -19, 20, rand_mant(), 1'b0);
	endtask

	task automatic test_large_diff();
		int d;
		int a_i;
		align_case(fpu_op_pkg::OP_AF, -20, 20, rand_mant(), 1'b0);
		align_case(fpu_op_pkg::OP_AF, -128, 127, rand_mant(), 1'b0);
		align_case(fpu_op_pkg::OP_SF, 20, -20, rand_mant(), 1'b0);
		align_case(fpu_op_pkg::OP_SF, 127, -128, rand_mant(), 1'b0);
		for (int k = 0; k < 10; k++) begin
			d = 40 + int'($urandom % 216);
			a_i = -128 + int'($urandom % (256 - d));
			align_case(fpu_op_pkg::OP_AF, a_i, a_i + d, rand_mant(), 1'b0);
			align_case(fpu_op_pkg::OP_SF, a_i + d, a_i, rand_mant(), 1'b0);
		end
	endtask

	task automatic test_exp_ops();
		// limits on both sides
		exp_case(fpu_op_pkg::OP_MF, 64, 63);
		exp_case(fpu_op_pkg::OP_MF, 64, 64);
		exp_case(fpu_op_pkg::OP_MF, -64, -64);
		exp_case(fpu_op_pkg::OP_MF, -64, -65);
		exp_case(fpu_op_pkg::OP_MF, -128, -128);
		exp_case(fpu_op_pkg::OP_MF, 127, 127);
		exp_case(fpu_op_pkg::OP_DF, 127, -1);
		exp_case(fpu_op_pkg::OP_DF, 126, -1);
		exp_case(fpu_op_pkg::OP_DF, -128, 1);
		exp_case(fpu_op_pkg::OP_DF, -1, 127);
		exp_case(fpu_op_pkg::OP_DF, 127, -128);
		exp_case(fpu_op_pkg::OP_DF, -128, 127);
		for (int k = 0; k < 20; k++) begin
			exp_case(k[0] ? fpu_op_pkg::OP_DF : fpu_op_pkg::OP_MF,
				int'(fpu_num_pkg::exponent_t'($urandom)),
				int'(fpu_num_pkg::exponent_t'($urandom)));
		end
	endtask

	task automatic test_fixed_and_status();
		logic [MANT_W-1:0] m;
		int a_i;
		for (int op = 0; op < 4; op++) begin
			m = rand_mant();
			a_i = int'(fpu_num_pkg::exponent_t'($urandom));
			run_op(fpu_op_pkg::op_code_t'(op), a_i, int'(fpu_num_pkg::exponent_t'($urandom)),
				m, 0, 1'b0);
			check_result(a_i, m, 1'b0, 1'b0, 1'b0, 1'b0);
			check_flag("ss", ss, 1'b1);
			check_flag("ff", ff, 1'b0);
		end
		// equal exponents, mantissa kept as chosen
		align_case(fpu_op_pkg::OP_AF, 5, 5, 40'h00_0000_0000, 1'b0);
		align_case(fpu_op_pkg::OP_AF, 5, 5, 40'h40_0000_0000, 1'b0);
		align_case(fpu_op_pkg::OP_AF, 5, 5, 40'h80_0000_0000, 1'b0);
		align_case(fpu_op_pkg::OP_AF, 5, 5, 40'hc0_0000_0000, 1'b0);
		align_case(fpu_op_pkg::OP_SF, 5, 5, 40'h3f_ffff_ffff, 1'b0);
		align_case(fpu_op_pkg::OP_SF, 5, 5, 40'h00_0000_0001, 1'b0);
		align_case(fpu_op_pkg::OP_SF, 5, 5, 40'hff_ffff_ffff, 1'b0);
		// shifted down to a single sign bit pattern
		align_case(fpu_op_pkg::OP_AF, 0, 39, 40'h80_0000_0000, 1'b0);
	endtask

	task automatic test_start_while_busy();
		align_case(fpu_op_pkg::OP_AF, -39, 0, rand_mant(), 1'b1);
		align_case(fpu_op_pkg::OP_SF, 10, 45, 40'h7f_0000_1234, 1'b1);
	endtask

	initial begin
		_0_f = 1'b1;
		start = 1'b0;
		ir = '0;
		exp_a = '0;
		exp_b = '0;
		mant_in = '0;
		void'($urandom(32'h6a4d));
		repeat (2) @(posedge clk_sys);
		#5;
		_0_f = 1'b0;
		test_reset();
		test_align();
		test_large_diff();
		test_exp_ops();
		test_fixed_and_status();
		test_start_while_busy();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
source/fpu_num_pkg.sv
source/fpu_op_pkg.sv
source/op_decoder.sv
source/exp_path.sv
source/align_seq.sv
source/mant_byte_slice.sv
source/mant_status.sv
source/fpu_align_top.sv
verif/fpu_align_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module fpu_align_tb -f build.f \
	-o fpu_align_sim > build.log 2>&1 || { cat build.log; echo "compile failed"; exit 1; }
./obj_dir/fpu_align_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no pass result in log"; exit 1; }
exit 0
